// ==== common/autocat_pkg.sv ====
package autocat_pkg;

    // defaults for the top level parameters
    parameter int unsigned DEFAULT_ASSOCIATIVITY = 16;
    parameter int unsigned DEFAULT_COUNTER_LEN   = 32;
    parameter int unsigned DEFAULT_RESET_REQUEST = 32'h0010_0000;
    parameter int unsigned DEFAULT_SHARE_SHIFT   = 3;

    // requests seen in the current epoch
    typedef logic [63:0] access_count_t;

    // scan sequencing after an epoch boundary
    typedef enum logic [1:0]
    {
        IDLE      = 2'd0,
        SUM_SCAN  = 2'd1,
        MARK_SCAN = 2'd2,
        PUBLISH   = 2'd3
    } epoch_state_t;

endpackage

// ==== source/epoch_control.sv ====
`timescale 1ns/1ps

module epoch_control
#(
    parameter int unsigned CACHE_ASSOCIATIVITY = autocat_pkg::DEFAULT_ASSOCIATIVITY,
    localparam int unsigned WAY_IDX_W = (CACHE_ASSOCIATIVITY > 1) ? $clog2(CACHE_ASSOCIATIVITY) : 1
)
(
    input  logic                 clk_in,
    input  logic                 reset_with_request_limit,
    input  logic                 epoch_end,
    output logic                 snapshot,
    output logic                 sum_en,
    output logic                 mark_en,
    output logic                 publish,
    output logic [WAY_IDX_W-1:0] scan_way
);

    localparam logic [WAY_IDX_W-1:0] LAST_WAY = WAY_IDX_W'(CACHE_ASSOCIATIVITY - 1);

    autocat_pkg::epoch_state_t state;
    logic [WAY_IDX_W-1:0]      way_idx;

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            state   <= autocat_pkg::IDLE;
            way_idx <= '0;
        end
        else
        begin
            case (state)
                autocat_pkg::IDLE:
                begin
                    way_idx <= '0;
                    if (epoch_end)
                        state <= autocat_pkg::SUM_SCAN;
                end
                autocat_pkg::SUM_SCAN:
                begin
                    if (way_idx == LAST_WAY)
                    begin
                        way_idx <= '0;
                        state   <= autocat_pkg::MARK_SCAN; // sum complete, threshold is final
                    end
                    else
                        way_idx <= way_idx + 1'b1;
                end
                autocat_pkg::MARK_SCAN:
                begin
                    if (way_idx == LAST_WAY)
                    begin
                        way_idx <= '0;
                        state   <= autocat_pkg::PUBLISH;
                    end
                    else
                        way_idx <= way_idx + 1'b1;
                end
                default:
                    state <= autocat_pkg::IDLE;
            endcase
        end
    end

    assign snapshot = epoch_end; // bank load lines up with the boundary
    assign sum_en   = (state == autocat_pkg::SUM_SCAN);
    assign mark_en  = (state == autocat_pkg::MARK_SCAN);
    assign publish  = (state == autocat_pkg::PUBLISH);
    assign scan_way = way_idx;

    // a new epoch must not end while the previous snapshot is still being scanned
    a_epoch_end_in_idle: assert property (
        @(posedge clk_in) disable iff (reset_with_request_limit)
        epoch_end |-> (state == autocat_pkg::IDLE)
    );

endmodule

// ==== monitor/access_counter.sv ====
`timescale 1ns/1ps

module access_counter
#(
    parameter int unsigned RESET_REQUEST = autocat_pkg::DEFAULT_RESET_REQUEST
)
(
    input  logic                       clk_in,
    input  logic                       reset_with_request_limit,
    input  logic                       access_valid,
    output autocat_pkg::access_count_t access_count,
    output logic                       epoch_end
);

    localparam autocat_pkg::access_count_t LAST_ACCESS =
        autocat_pkg::access_count_t'(RESET_REQUEST - 1);

    logic access_valid_pre;
    logic access_edge;

    assign access_edge = access_valid & ~access_valid_pre;

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            access_valid_pre <= 1'b0;
            access_count     <= '0;
            epoch_end        <= 1'b0;
        end
        else
        begin
            access_valid_pre <= access_valid;
            epoch_end        <= 1'b0;
            if (access_edge)
            begin
                if (access_count == LAST_ACCESS)
                begin
                    access_count <= '0; // epoch limit reached
                    epoch_end    <= 1'b1;
                end
                else
                    access_count <= access_count + 1'b1;
            end
        end
    end

    a_count_below_limit: assert property (
        @(posedge clk_in) disable iff (reset_with_request_limit)
        access_count < autocat_pkg::access_count_t'(RESET_REQUEST)
    );

endmodule

// ==== monitor/way_hit_counters.sv ====
`timescale 1ns/1ps

module way_hit_counters
#(
    parameter int unsigned CACHE_ASSOCIATIVITY = autocat_pkg::DEFAULT_ASSOCIATIVITY,
    parameter int unsigned COUNTER_LEN         = autocat_pkg::DEFAULT_COUNTER_LEN,
    localparam int unsigned WAY_IDX_W = (CACHE_ASSOCIATIVITY > 1) ? $clog2(CACHE_ASSOCIATIVITY) : 1
)
(
    input  logic                                       clk_in,
    input  logic                                       reset_with_request_limit,
    input  logic [CACHE_ASSOCIATIVITY-1:0]             hit_vec,
    input  logic                                       snapshot,
    input  logic [WAY_IDX_W-1:0]                       scan_way,
    output logic [CACHE_ASSOCIATIVITY*COUNTER_LEN-1:0] cat_counter_flatted,
    output logic [COUNTER_LEN-1:0]                     scan_count
);

    typedef logic [COUNTER_LEN-1:0]         hit_count_t;
    typedef logic [CACHE_ASSOCIATIVITY-1:0] way_vec_t;

    way_vec_t   hit_vec_pre;
    way_vec_t   hit_edge;
    hit_count_t live_count [CACHE_ASSOCIATIVITY];
    hit_count_t snap_bank  [CACHE_ASSOCIATIVITY];

    assign hit_edge = hit_vec & ~hit_vec_pre;

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
            hit_vec_pre <= '0;
        else
            hit_vec_pre <= hit_vec;
    end

    for (genvar w = 0; w < CACHE_ASSOCIATIVITY; w++)
    begin : g_way
        always_ff @(posedge clk_in or posedge reset_with_request_limit)
        begin
            if (reset_with_request_limit)
                live_count[w] <= '0;
            else if (snapshot)
                live_count[w] <= hit_count_t'(hit_edge[w]); // edge here opens the new epoch
            else if (hit_edge[w] && (live_count[w] != '1))
                live_count[w] <= live_count[w] + 1'b1;
        end

        always_ff @(posedge clk_in)
        begin
            if (snapshot)
                snap_bank[w] <= live_count[w];
        end

        assign cat_counter_flatted[w*COUNTER_LEN +: COUNTER_LEN] = live_count[w];

        // only a snapshot may bring a full counter back to zero
        a_no_wrap: assert property (
            @(posedge clk_in) disable iff (reset_with_request_limit)
            ((live_count[w] == '1) && !snapshot) |=> (live_count[w] != '0)
        );
    end

    assign scan_count = snap_bank[scan_way];

endmodule

// ==== selector/waymask_selector.sv ====
`timescale 1ns/1ps

module waymask_selector
#(
    parameter int unsigned CACHE_ASSOCIATIVITY = autocat_pkg::DEFAULT_ASSOCIATIVITY,
    parameter int unsigned COUNTER_LEN         = autocat_pkg::DEFAULT_COUNTER_LEN,
    parameter int unsigned SHARE_SHIFT         = autocat_pkg::DEFAULT_SHARE_SHIFT,
    localparam int unsigned WAY_IDX_W = (CACHE_ASSOCIATIVITY > 1) ? $clog2(CACHE_ASSOCIATIVITY) : 1
)
(
    input  logic                           clk_in,
    input  logic                           reset_with_request_limit,
    input  logic                           snapshot,
    input  logic                           sum_en,
    input  logic                           mark_en,
    input  logic                           publish,
    input  logic [WAY_IDX_W-1:0]           scan_way,
    input  logic [COUNTER_LEN-1:0]         scan_count,
    output logic [CACHE_ASSOCIATIVITY-1:0] suggested_waymask,
    output logic                           waymask_valid
);

    // room for every way at full count
    localparam int unsigned SUM_W = COUNTER_LEN + WAY_IDX_W;

    typedef logic [SUM_W-1:0]               hit_sum_t;
    typedef logic [CACHE_ASSOCIATIVITY-1:0] way_vec_t;

    hit_sum_t hit_sum;
    hit_sum_t threshold;
    hit_sum_t scan_count_ext;
    way_vec_t mark_vec;
    logic     way_hot;

    assign scan_count_ext = hit_sum_t'(scan_count);
    assign threshold      = hit_sum >> SHARE_SHIFT;
    assign way_hot        = (scan_count != '0) && (scan_count_ext >= threshold);

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            hit_sum  <= '0;
            mark_vec <= '0;
        end
        else if (snapshot)
        begin
            hit_sum  <= '0; // fresh evaluation
            mark_vec <= '0;
        end
        else
        begin
            if (sum_en)
                hit_sum <= hit_sum + scan_count_ext;
            if (mark_en)
                mark_vec[scan_way] <= way_hot;
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            suggested_waymask <= '1;
            waymask_valid     <= 1'b0;
        end
        else
        begin
            waymask_valid <= publish;
            if (publish)
                suggested_waymask <= (mark_vec == '0) ? '1 : mark_vec; // nothing hot, open all ways
        end
    end

endmodule

// ==== source/autocat_top.sv ====
`timescale 1ns/1ps

module autocat_top
#(
    parameter int unsigned CACHE_ASSOCIATIVITY = autocat_pkg::DEFAULT_ASSOCIATIVITY,
    parameter int unsigned COUNTER_LEN         = autocat_pkg::DEFAULT_COUNTER_LEN,
    parameter int unsigned RESET_REQUEST       = autocat_pkg::DEFAULT_RESET_REQUEST,
    parameter int unsigned SHARE_SHIFT         = autocat_pkg::DEFAULT_SHARE_SHIFT
)
(
    input  logic                                         clk_in,
    input  logic                                         reset_with_request_limit,
    input  logic [63:0]                                  set_address,
    input  logic                                         access_valid,
    input  logic [CACHE_ASSOCIATIVITY-1:0]               hit_vec,
    output logic [CACHE_ASSOCIATIVITY*COUNTER_LEN-1:0]   cat_counter_flatted,
    output logic [CACHE_ASSOCIATIVITY-1:0]               suggested_waymask,
    output logic                                         waymask_valid
);

    localparam int unsigned WAY_IDX_W = (CACHE_ASSOCIATIVITY > 1) ? $clog2(CACHE_ASSOCIATIVITY) : 1;

    autocat_pkg::access_count_t access_count; // only watched by the counter assertion
    logic                       epoch_end;
    logic                       snapshot;
    logic                       sum_en;
    logic                       mark_en;
    logic                       publish;
    logic [WAY_IDX_W-1:0]       scan_way;
    logic [COUNTER_LEN-1:0]     scan_count;

    epoch_control
    #(
        .CACHE_ASSOCIATIVITY (CACHE_ASSOCIATIVITY)
    )
    u_epoch_control
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .epoch_end                (epoch_end),
        .snapshot                 (snapshot),
        .sum_en                   (sum_en),
        .mark_en                  (mark_en),
        .publish                  (publish),
        .scan_way                 (scan_way)
    );

    access_counter
    #(
        .RESET_REQUEST (RESET_REQUEST)
    )
    u_access_counter
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_valid             (access_valid),
        .access_count             (access_count),
        .epoch_end                (epoch_end)
    );

    way_hit_counters
    #(
        .CACHE_ASSOCIATIVITY (CACHE_ASSOCIATIVITY),
        .COUNTER_LEN         (COUNTER_LEN)
    )
    u_way_hit_counters
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .hit_vec                  (hit_vec),
        .snapshot                 (snapshot),
        .scan_way                 (scan_way),
        .cat_counter_flatted      (cat_counter_flatted),
        .scan_count               (scan_count)
    );

    waymask_selector
    #(
        .CACHE_ASSOCIATIVITY (CACHE_ASSOCIATIVITY),
        .COUNTER_LEN         (COUNTER_LEN),
        .SHARE_SHIFT         (SHARE_SHIFT)
    )
    u_waymask_selector
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .snapshot                 (snapshot),
        .sum_en                   (sum_en),
        .mark_en                  (mark_en),
        .publish                  (publish),
        .scan_way                 (scan_way),
        .scan_count               (scan_count),
        .suggested_waymask        (suggested_waymask),
        .waymask_valid            (waymask_valid)
    );

endmodule

// ==== sim/tb_autocat.sv ====
`timescale 1ns/1ps

module tb_autocat;

    localparam int WAYS        = 8;
    localparam int CLEN        = 4;
    localparam int REQS        = 32;
    localparam int SHIFT       = 3;
    localparam int CMAX        = (1 << CLEN) - 1;
    localparam int NUM_ROWS    = 6;
    localparam int ROW_CYCLES  = 64 + 2 * WAYS + 10;
    localparam int WATCHDOG_NS = (NUM_ROWS + 2) * ROW_CYCLES * 8; // two extra rows for resets
    localparam int MISS        = WAYS; // access codes above the way numbers
    localparam int HELD        = WAYS + 1;

    typedef logic [WAYS-1:0] mask_t;
    typedef logic [CLEN-1:0] count_t;

    logic                   clk_in;
    logic                   reset_with_request_limit;
    logic [63:0]            set_address;
    logic                   access_valid;
    mask_t                  hit_vec;
    logic [WAYS*CLEN-1:0]   cat_counter_flatted;
    mask_t                  suggested_waymask;
    logic                   waymask_valid;

    // each row is one epoch of hits per way, misses and held repeats
    int row_hits [NUM_ROWS][WAYS] = '{
        '{4, 4, 4, 4, 4, 4, 4, 4},
        '{10, 2, 0, 0, 5, 0, 0, 1},
        '{0, 0, 0, 0, 0, 0, 0, 0},
        '{20, 2, 2, 0, 0, 0, 0, 0},
        '{1, 0, 0, 6, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 3, 3}
    };
    int row_misses     [NUM_ROWS] = '{0, 14, 32, 8, 20, 26};
    int row_hold_way   [NUM_ROWS] = '{0, 0, 0, 0, 3, 0};
    int row_hold_extra [NUM_ROWS] = '{0, 0, 0, 0, 5, 0}; // way 3 stays high into row 5

    logic [31:0] rng_state = 32'd29;
    int          order [REQS];
    int          live_model [WAYS];

    autocat_top
    #(
        .CACHE_ASSOCIATIVITY (WAYS),
        .COUNTER_LEN         (CLEN),
        .RESET_REQUEST       (REQS),
        .SHARE_SHIFT         (SHIFT)
    )
    u_autocat_top
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .set_address              (set_address),
        .access_valid             (access_valid),
        .hit_vec                  (hit_vec),
        .cat_counter_flatted      (cat_counter_flatted),
        .suggested_waymask        (suggested_waymask),
        .waymask_valid            (waymask_valid)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        stop_with_failure("the run did not finish before the watchdog expired");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    task automatic check_mask(input string name, input mask_t actual, input mask_t expected);
        if (actual !== expected)
            stop_with_failure($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
                                        $time, name, actual, expected));
    endtask

    task automatic check_counter(input string name, input count_t actual, input count_t expected);
        if (actual !== expected)
            stop_with_failure($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
                                        $time, name, actual, expected));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            stop_with_failure($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                        $time, name, actual, expected));
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected)
            stop_with_failure($sformatf("Fail at %0t ns: %s is %0d cycles, expected %0d",
                                        $time, name, actual, expected));
    endtask

    // mask rule on saturated counts
    function automatic mask_t model_mask(input int row);
        int    sat [WAYS];
        int    sum;
        int    thr;
        mask_t m;
        sum = 0;
        m   = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            sat[w] = (row_hits[row][w] > CMAX) ? CMAX : row_hits[row][w];
            sum    = sum + sat[w];
        end
        thr = sum >> SHIFT;
        for (int w = 0; w < WAYS; w++)
            if (sat[w] != 0 && sat[w] >= thr)
                m[w] = 1'b1;
        if (m == '0)
            m = '1;
        return m;
    endfunction

    task automatic check_live_counters();
        for (int w = 0; w < WAYS; w++)
            check_counter($sformatf("cat_counter_flatted[way %0d]", w),
                          cat_counter_flatted[w*CLEN +: CLEN], count_t'(live_model[w]));
    endtask

    task automatic check_reset_state();
        check_mask("suggested_waymask", suggested_waymask, '1);
        check_flag("waymask_valid", waymask_valid, 1'b0);
        for (int w = 0; w < WAYS; w++)
            live_model[w] = 0;
        check_live_counters();
    endtask

    // shuffled hits and misses followed by the held group
    task automatic build_order(input int row, output int n, output int held_start);
        int          cnt;
        int          j;
        int          tmp;
        logic [31:0] r;
        n = 0;
        for (int w = 0; w < WAYS; w++)
        begin
            cnt = row_hits[row][w];
            if (row_hold_extra[row] > 0 && w == row_hold_way[row])
                cnt = cnt - 1;
            for (int k = 0; k < cnt; k++)
            begin
                order[n] = w;
                n        = n + 1;
            end
        end
        for (int k = 0; k < row_misses[row]; k++)
        begin
            order[n] = MISS;
            n        = n + 1;
        end
        for (int i = n - 1; i > 0; i--)
        begin
            draw_random(r);
            j        = int'(r % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        held_start = n;
        if (row_hold_extra[row] > 0)
        begin
            order[n] = row_hold_way[row];
            n        = n + 1;
            for (int k = 0; k < row_hold_extra[row]; k++)
            begin
                order[n] = HELD;
                n        = n + 1;
            end
        end
    endtask

    // one access high for a cycle and low for a cycle from a falling edge
    task automatic drive_access(input int code, input logic keep_hit);
        logic [31:0] r;
        draw_random(r);
        set_address  = {r, ~r};
        access_valid = 1'b1;
        if (code < WAYS)
            hit_vec = mask_t'(1) << code;
        else if (code == MISS)
            hit_vec = '0;
        @(negedge clk_in);
        if (code < WAYS && live_model[code] < CMAX)
            live_model[code] = live_model[code] + 1;
        check_live_counters();
        access_valid = 1'b0;
        if (!keep_hit)
            hit_vec = '0;
        @(negedge clk_in);
    endtask

    task automatic run_row(input int row);
        int n;
        int held_start;
        int waited;
        build_order(row, n, held_start);
        if (n != REQS)
            stop_with_failure($sformatf("stimulus row %0d does not add up to one epoch", row));
        access_valid = 1'b0;
        hit_vec      = '0; // drops a hit held over from the last row
        for (int w = 0; w < WAYS; w++)
            live_model[w] = 0;
        @(negedge clk_in);
        check_live_counters();
        for (int i = 0; i < n; i++)
            drive_access(order[i], i >= held_start);
        waited = 1; // last edge sampled one cycle back
        while (!waymask_valid && waited < 40)
        begin
            @(negedge clk_in);
            waited = waited + 1;
        end
        if (!waymask_valid)
            stop_with_failure($sformatf("waymask_valid never pulsed after epoch %0d", row));
        check_latency("waymask_valid latency", waited, 2 * WAYS + 2);
        check_mask("suggested_waymask", suggested_waymask, model_mask(row));
        @(negedge clk_in);
        check_flag("waymask_valid", waymask_valid, 1'b0);
    endtask

    initial
    begin
        reset_with_request_limit = 1'b1;
        set_address              = '0;
        access_valid             = 1'b0;
        hit_vec                  = '0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset_with_request_limit = 1'b0;
        check_reset_state();
        for (int row = 0; row < NUM_ROWS; row++)
            run_row(row);
        // partial epoch followed by an asynchronous reset between clock edges
        for (int w = 0; w < WAYS; w++)
            live_model[w] = 0; // counters restarted at the last epoch end
        for (int k = 0; k < 4; k++)
            drive_access(2, 1'b0);
        reset_with_request_limit = 1'b1;
        #1;
        check_reset_state();
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset_with_request_limit = 1'b0;
        run_row(0);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sim.f ====
common/autocat_pkg.sv
source/epoch_control.sv
monitor/access_counter.sv
monitor/way_hit_counters.sv
selector/waymask_selector.sv
source/autocat_top.sv
sim/tb_autocat.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_autocat -o tb_autocat \
    && ./obj_dir/tb_autocat | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
